// File: Makefile
# Verilator build and run of the data cache testbench.

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module dcache_tb -f vlog.f
	@out="$$(./obj_dir/Vdcache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: logic/dcache_ctrl.sv
/*
 Data cache controller.
 Direct-mapped write-back cache FSM: invalidates all lines after reset,
 serves cacheable reads and writes with victim write-back, forwards
 uncacheable accesses to the bus and flushes every dirty line on command.
 Also strobes hit and miss events for the counters.
*/
module dcache_ctrl (
	input  logic        i_clock,
	input  logic        i_reset,

	// Requester.
	input  logic        i_request,
	input  logic        i_rw,
	input  logic        i_flush,
	input  logic        i_cacheable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata,

	// Memory bus.
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata,

	// Line store.
	line_ram_if.ctrl    ram,

	// Statistics.
	output logic        o_hit_pulse,
	output logic        o_miss_pulse
);
	import dcache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Line walker shared by init and flush.
	// One bit wider so flush can see the end.
	logic [index_bits:0] walk_count;
	logic [index_bits:0] next_walk_count;

	logic [index_bits-1:0] req_index;
	logic [29:0]           req_tag;
	logic                  tag_hit;
	logic                  dirty_conflict;
	logic [31:0]           victim_address;
	line_entry_t           store_entry;
	line_entry_t           fill_entry;
	line_entry_t           clean_entry;

	// ==========================================================================
	// Request decode
	// ==========================================================================

	assign req_index = i_address[index_bits+1:2];
	assign req_tag   = i_address[31:2];

	// Entry read back is the one at the request index.
	assign tag_hit        = ram.rentry.valid && (ram.rentry.tag == req_tag);
	assign dirty_conflict = ram.rentry.valid && ram.rentry.dirty && !tag_hit;
	assign victim_address = {ram.rentry.tag, 2'b00};

	// Entries the controller may write.
	assign store_entry = '{valid: 1'b1, dirty: 1'b1, tag: req_tag, data: i_wdata};
	assign fill_entry  = '{valid: 1'b1, dirty: 1'b0, tag: req_tag, data: i_bus_rdata};
	assign clean_entry = '{valid: 1'b1, dirty: 1'b0, tag: ram.rentry.tag,
		data: ram.rentry.data};

	// ==========================================================================
	// State registers
	// ==========================================================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state      <= init;
			walk_count <= '0;
		end else begin
			state      <= next_state;
			walk_count <= next_walk_count;
		end
	end

	// ==========================================================================
	// Next state and outputs
	// ==========================================================================

	always_comb begin
		next_state      = state;
		next_walk_count = walk_count;

		o_ready       = 1'b0;
		o_rdata       = '0;
		o_bus_request = 1'b0;
		o_bus_rw      = 1'b0;
		o_bus_address = '0;
		o_bus_wdata   = '0;
		o_hit_pulse   = 1'b0;
		o_miss_pulse  = 1'b0;

		ram.write  = 1'b0;
		ram.index  = req_index;
		ram.wentry = '0;

		case (state)
			// Invalidate one line per cycle.
			init: begin
				ram.write  = 1'b1;
				ram.index  = walk_count[index_bits-1:0];
				ram.wentry = '0;
				if (walk_count == (index_bits + 1)'(line_count - 1)) begin
					next_walk_count = '0;
					next_state      = idle;
				end else begin
					next_walk_count = walk_count + 1'b1;
				end
			end

			// RAM is indexed by the request address here.
			idle: begin
				if (i_request) begin
					if (i_flush) begin
						next_walk_count = '0;
						next_state      = flush_setup;
					end else if (!i_cacheable) begin
						next_state = pass;
					end else if (i_rw) begin
						next_state = write_setup;
					end else begin
						next_state = read_setup;
					end
				end
			end

			// Uncacheable access goes straight to the bus.
			pass: begin
				o_bus_request = i_request;
				o_bus_rw      = i_rw;
				o_bus_address = i_address;
				o_bus_wdata   = i_wdata;
				o_rdata       = i_bus_rdata;
				o_ready       = i_bus_ready;
				if (i_bus_ready) begin
					next_state = idle;
				end
			end

			// ======================================================================
			// Write
			// ======================================================================

			write_setup: begin
				o_hit_pulse  = tag_hit;
				o_miss_pulse = !tag_hit;
				if (dirty_conflict) begin
					next_state = write_wb;
				end else begin
					ram.write  = 1'b1;
					ram.wentry = store_entry;
					o_ready    = 1'b1;
					next_state = idle;
				end
			end

			// Victim goes out before the new word lands.
			write_wb: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = victim_address;
				o_bus_wdata   = ram.rentry.data;
				if (i_bus_ready) begin
					ram.write  = 1'b1;
					ram.wentry = store_entry;
					o_ready    = 1'b1;
					next_state = idle;
				end
			end

			// ======================================================================
			// Read
			// ======================================================================

			read_setup: begin
				o_rdata = ram.rentry.data;
				if (tag_hit) begin
					o_hit_pulse = 1'b1;
					o_ready     = 1'b1;
					next_state  = idle;
				end else begin
					o_miss_pulse = 1'b1;
					next_state   = ram.rentry.dirty ? read_wb : read_fill;
				end
			end

			read_wb: begin
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = victim_address;
				o_bus_wdata   = ram.rentry.data;
				if (i_bus_ready) begin
					next_state = read_fill;
				end
			end

			// Fetched word is returned and stored clean.
			read_fill: begin
				o_bus_request = 1'b1;
				o_bus_address = i_address;
				o_rdata       = i_bus_rdata;
				if (i_bus_ready) begin
					ram.write  = 1'b1;
					ram.wentry = fill_entry;
					o_ready    = 1'b1;
					next_state = idle;
				end
			end

			// ======================================================================
			// Flush
			// ======================================================================

			flush_setup: begin
				ram.index = walk_count[index_bits-1:0];
				if (walk_count == (index_bits + 1)'(line_count)) begin
					next_walk_count = '0;
					o_ready         = 1'b1;
					next_state      = idle;
				end else begin
					next_state = flush_check;
				end
			end

			flush_check: begin
				ram.index = walk_count[index_bits-1:0];
				if (ram.rentry.valid && ram.rentry.dirty) begin
					next_state = flush_write;
				end else begin
					next_walk_count = walk_count + 1'b1;
					next_state      = flush_setup;
				end
			end

			// Write back, then mark the line clean.
			flush_write: begin
				ram.index     = walk_count[index_bits-1:0];
				o_bus_request = 1'b1;
				o_bus_rw      = 1'b1;
				o_bus_address = victim_address;
				o_bus_wdata   = ram.rentry.data;
				if (i_bus_ready) begin
					ram.write  = 1'b1;
					ram.wentry = clean_entry;
					next_state = flush_next;
				end
			end

			flush_next: begin
				ram.index       = walk_count[index_bits-1:0];
				next_walk_count = walk_count + 1'b1;
				next_state      = flush_setup;
			end

			default: begin
				next_state = idle;
			end
		endcase
	end

endmodule

// File: logic/dcache_pkg.sv
/*
 Data cache package.
 Cache geometry, the stored line entry and the controller states,
 shared by the line RAM, its interface and the cache controller.
*/
package dcache_pkg;

	// ==========================================================================
	// Geometry
	// ==========================================================================

	// Kept small so that index conflicts are frequent.
	localparam int unsigned index_bits = 4;
	localparam int unsigned line_count = 1 << index_bits;

	// One word per line, tagged by its full word address.
	typedef struct packed {
		logic        valid;
		logic        dirty;
		logic [29:0] tag;
		logic [31:0] data;
	} line_entry_t;

	// ==========================================================================
	// Controller states
	// ==========================================================================

	typedef enum logic [3:0] {
		init,
		idle,
		pass,
		write_setup,
		write_wb,
		read_setup,
		read_wb,
		read_fill,
		flush_setup,
		flush_check,
		flush_write,
		flush_next
	} ctrl_state_t;

endpackage

// File: logic/dcache_stats.sv
/*
 Cache statistics.
 Saturating hit and miss counters fed by one-cycle strobes from the
 controller. Cleared on reset.
*/
module dcache_stats (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_hit_pulse,
	input  logic        i_miss_pulse,
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hit_count  <= '0;
			o_miss_count <= '0;
		end else begin
			// Hold at the maximum.
			if (i_hit_pulse && (o_hit_count != '1)) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
			if (i_miss_pulse && (o_miss_count != '1)) begin
				o_miss_count <= o_miss_count + 1'b1;
			end
		end
	end

endmodule

// File: logic/dcache_top.sv
/*
 Data cache top level.
 Direct-mapped write-back cache between a CPU load/store port and a
 32-bit memory bus, with hit and miss counters.
*/
module dcache_top (
	input  logic        i_clock,
	input  logic        i_reset,

	// Requester.
	input  logic        i_request,
	input  logic        i_rw,
	input  logic        i_flush,
	input  logic        i_cacheable,
	input  logic [31:0] i_address,
	input  logic [31:0] i_wdata,
	output logic        o_ready,
	output logic [31:0] o_rdata,

	// Memory bus.
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output logic [31:0] o_bus_address,
	output logic [31:0] o_bus_wdata,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata,

	// Statistics.
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	logic hit_pulse;
	logic miss_pulse;

	line_ram_if ram_bus ();

	dcache_ctrl ctrl_i (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_request     (i_request),
		.i_rw          (i_rw),
		.i_flush       (i_flush),
		.i_cacheable   (i_cacheable),
		.i_address     (i_address),
		.i_wdata       (i_wdata),
		.o_ready       (o_ready),
		.o_rdata       (o_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_rw      (o_bus_rw),
		.o_bus_address (o_bus_address),
		.o_bus_wdata   (o_bus_wdata),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.ram           (ram_bus.ctrl),
		.o_hit_pulse   (hit_pulse),
		.o_miss_pulse  (miss_pulse)
	);

	line_ram ram_i (
		.i_clock (i_clock),
		.ram     (ram_bus.ram)
	);

	dcache_stats stats_i (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_hit_pulse  (hit_pulse),
		.i_miss_pulse (miss_pulse),
		.o_hit_count  (o_hit_count),
		.o_miss_count (o_miss_count)
	);

endmodule

// File: logic/line_ram.sv
/*
 Line RAM.
 Single-port store of cache line entries. The addressed entry is read
 on every clock, so it appears one cycle after its index; a write lands
 at the same clock edge.
*/
module line_ram (
	input logic     i_clock,
	line_ram_if.ram ram
);
	import dcache_pkg::*;

	// Contents come up undefined.
	// The controller invalidates every line after reset.
	line_entry_t lines [line_count];

	// Synchronous write.
	always_ff @(posedge i_clock) begin
		if (ram.write) begin
			lines[ram.index] <= ram.wentry;
		end
	end

	// Registered read, old contents on a write to the same index.
	always_ff @(posedge i_clock) begin
		ram.rentry <= lines[ram.index];
	end

endmodule

// File: logic/line_ram_if.sv
/*
 Line RAM interface.
 Connects the cache controller to the line store: one index, a write
 strobe with its entry, and the entry read back one cycle later.
*/
interface line_ram_if;
	import dcache_pkg::*;

	logic                  write;
	logic [index_bits-1:0] index;
	line_entry_t           wentry;
	// Entry at the index of the previous cycle.
	line_entry_t           rentry;

	modport ctrl (
		output write, index, wentry,
		input  rentry
	);

	modport ram (
		input  write, index, wentry,
		output rentry
	);

endinterface

// File: sim/bus_memory_model.sv
/*
 Bus memory model.
 Word memory on the bus side of the cache. Each transfer completes after
 0 to 3 cycles drawn from an LFSR; read data follows the address.
*/
module bus_memory_model (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic        i_bus_request,
	input  logic        i_bus_rw,
	input  logic [31:0] i_bus_address,
	input  logic [31:0] i_bus_wdata,
	output logic        o_bus_ready,
	output logic [31:0] o_bus_rdata
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int word_count = 128;

	logic [31:0] mem [word_count];
	logic [15:0] lfsr;
	// Delay of the next transfer, drawn when the previous one ends.
	logic [1:0]  delay;
	logic [1:0]  waited;

	// Fibonacci LFSR, taps 16 14 13 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	assign o_bus_ready = i_bus_request && (waited == delay);
	assign o_bus_rdata = mem[i_bus_address[8:2]];

	always @(posedge i_clock) begin : transfer
		logic [15:0] state;
		logic [1:0]  pick;
		if (i_reset) begin
			// Fill pattern from the whole byte address.
			for (int k = 0; k < word_count; k++) begin
				mem[k] <= (32'(k) * 32'd4 + 32'd1) * 32'h9e3779b9;
			end
			lfsr   <= 16'd2;
			delay  <= 2'd0;
			waited <= 2'd0;
		end else if (i_bus_request) begin
			if (o_bus_ready) begin
				if (i_bus_rw) begin
					mem[i_bus_address[8:2]] <= i_bus_wdata;
				end
				state   = lfsr_next(lfsr);
				pick[0] = state[0];
				state   = lfsr_next(state);
				pick[1] = state[0];
				lfsr   <= state;
				delay  <= pick;
				waited <= 2'd0;
			end else begin
				waited <= waited + 2'd1;
			end
		end
	end

endmodule

// File: sim/dcache_tb.sv
/*
 Data cache testbench.
 Runs directed and random cacheable, uncacheable and flush requests
 against a shadow memory and a shadow tag array. Checks read data, bus
 writes, write-back counts, hit latency and the hit and miss counters.
*/
module dcache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import dcache_pkg::*;

	// ==========================================================================
	// Test constants
	// ==========================================================================

	localparam int reset_cycles   = 3;
	localparam int op_count       = 300;
	localparam int directed_count = 7;
	localparam int uncached_base  = 64;
	localparam int memory_words   = 128;
	// Two bus transfers at most per access, a full walk per flush.
	localparam int cycle_limit = reset_cycles + int'(line_count)
		+ (op_count + directed_count) * 20 * 2 + 2 * int'(line_count) * 20;

	logic        clock;
	logic        reset;
	logic        request;
	logic        rw;
	logic        flush;
	logic        cacheable;
	logic [31:0] address;
	logic [31:0] wdata;
	logic        ready;
	logic [31:0] rdata;
	logic        bus_request;
	logic        bus_rw;
	logic [31:0] bus_address;
	logic [31:0] bus_wdata;
	logic        bus_ready;
	logic [31:0] bus_rdata;
	logic [31:0] hit_count;
	logic [31:0] miss_count;

	// Architectural memory and the expected cache contents.
	logic [31:0] shadow_mem [memory_words];
	logic        shadow_valid [line_count];
	logic        shadow_dirty [line_count];
	logic [29:0] shadow_tag [line_count];

	logic [15:0] lfsr_state;
	logic        pass_active;
	int          errors;
	int          cycle;
	int          bus_writes;
	int          bus_transfers;
	int          expected_hits;
	int          expected_misses;

	dcache_top dut_i (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_request     (request),
		.i_rw          (rw),
		.i_flush       (flush),
		.i_cacheable   (cacheable),
		.i_address     (address),
		.i_wdata       (wdata),
		.o_ready       (ready),
		.o_rdata       (rdata),
		.o_bus_request (bus_request),
		.o_bus_rw      (bus_rw),
		.o_bus_address (bus_address),
		.o_bus_wdata   (bus_wdata),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_hit_count   (hit_count),
		.o_miss_count  (miss_count)
	);

	bus_memory_model memory_i (
		.i_clock       (clock),
		.i_reset       (reset),
		.i_bus_request (bus_request),
		.i_bus_rw      (bus_rw),
		.i_bus_address (bus_address),
		.i_bus_wdata   (bus_wdata),
		.o_bus_ready   (bus_ready),
		.o_bus_rdata   (bus_rdata)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	task automatic report_error(input string what);
		$display("FAIL at %0d ns: %s", $time, what);
		errors++;
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	// One LFSR step per bit taken.
	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		repeat (count) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	// ==========================================================================
	// Bus monitor and init window
	// ==========================================================================

	initial begin : bus_monitor
		forever begin
			@(posedge clock);
			cycle++;
			if (cycle >= 2 && cycle <= reset_cycles + int'(line_count)) begin
				assert (!ready && !bus_request)
					else report_error("ready or bus request during reset or init");
			end
			if (bus_request && bus_ready) begin
				bus_transfers++;
				if (bus_rw) begin
					bus_writes++;
					assert (bus_wdata == shadow_mem[bus_address[8:2]])
						else report_error($sformatf("bus write %h carries %h, expected %h",
							bus_address, bus_wdata, shadow_mem[bus_address[8:2]]));
				end
				// Uncacheable access is forwarded as issued.
				if (pass_active) begin
					assert (bus_address == address && bus_rw == rw && (!rw || bus_wdata == wdata))
						else report_error($sformatf("pass-through to %h altered on the bus", address));
				end
			end
		end
	end

	initial begin
		wait (cycle >= cycle_limit);
		$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Simulation failed");
		$finish;
	end

	// ==========================================================================
	// One request, predicted by the shadow model
	// ==========================================================================

	task automatic run_access(
		input logic        is_flush,
		input logic        is_cacheable,
		input logic        is_write,
		input logic [31:0] addr,
		input logic [31:0] data
	);
		logic [index_bits-1:0] index;
		logic                  hit;
		logic                  victim_dirty;
		logic [31:0]           expect_rdata;
		logic [31:0]           got_rdata;
		int                    expect_writes;
		int                    expect_transfers;
		int                    writes_before;
		int                    transfers_before;
		int                    wait_cycles;

		index            = addr[index_bits+1:2];
		hit              = shadow_valid[index] && (shadow_tag[index] == addr[31:2]);
		victim_dirty     = shadow_valid[index] && shadow_dirty[index] && !hit;
		expect_rdata     = shadow_mem[addr[8:2]];
		expect_writes    = 0;
		expect_transfers = 0;

		if (is_flush) begin
			for (int i = 0; i < int'(line_count); i++) begin
				if (shadow_valid[i] && shadow_dirty[i]) begin
					expect_writes++;
				end
				shadow_dirty[i] = 1'b0;
			end
			expect_transfers = expect_writes;
		end else if (!is_cacheable) begin
			expect_writes    = is_write ? 1 : 0;
			expect_transfers = 1;
		end else begin
			if (hit) begin
				expected_hits++;
			end else begin
				expected_misses++;
			end
			// Victim write-back, then a fill on a read miss.
			expect_writes       = victim_dirty ? 1 : 0;
			expect_transfers    = expect_writes + ((is_write || hit) ? 0 : 1);
			shadow_dirty[index] = is_write || (hit && shadow_dirty[index]);
			shadow_valid[index] = 1'b1;
			shadow_tag[index]   = addr[31:2];
		end
		if (is_write && !is_flush) begin
			shadow_mem[addr[8:2]] = data;
		end

		@(negedge clock);
		writes_before    = bus_writes;
		transfers_before = bus_transfers;
		request          = 1'b1;
		flush            = is_flush;
		cacheable        = is_cacheable;
		rw               = is_write;
		address          = addr;
		wdata            = data;
		pass_active      = !is_flush && !is_cacheable;

		wait_cycles = 0;
		do begin
			@(posedge clock);
			wait_cycles++;
		end while (!ready);
		got_rdata = rdata;

		@(negedge clock);
		request     = 1'b0;
		flush       = 1'b0;
		pass_active = 1'b0;

		if (!is_flush && !is_write) begin
			assert (got_rdata == expect_rdata)
				else report_error($sformatf("read of %h returned %h, expected %h",
					addr, got_rdata, expect_rdata));
		end
		assert (bus_writes - writes_before == expect_writes)
			else report_error($sformatf("%0d bus writes at %h, expected %0d",
				bus_writes - writes_before, addr, expect_writes));
		assert (bus_transfers - transfers_before == expect_transfers)
			else report_error($sformatf("%0d bus transfers at %h, expected %0d",
				bus_transfers - transfers_before, addr, expect_transfers));
		// Hit or clean store answers one cycle after acceptance.
		if (is_cacheable && !is_flush && expect_transfers == 0) begin
			assert (wait_cycles == 2)
				else report_error($sformatf("access to %h took %0d cycles", addr, wait_cycles));
		end
		assert (hit_count == expected_hits && miss_count == expected_misses)
			else report_error($sformatf("counters %0d/%0d, expected %0d/%0d",
				hit_count, miss_count, expected_hits, expected_misses));
	endtask

	// ==========================================================================
	// Stimulus
	// ==========================================================================

	initial begin
		logic [31:0] choice;
		logic [31:0] word;
		logic [31:0] data;

		reset           = 1'b1;
		request         = 1'b0;
		rw              = 1'b0;
		flush           = 1'b0;
		cacheable       = 1'b0;
		address         = '0;
		wdata           = '0;
		pass_active     = 1'b0;
		lfsr_state      = 16'd2;
		errors          = 0;
		bus_writes      = 0;
		bus_transfers   = 0;
		expected_hits   = 0;
		expected_misses = 0;
		for (int i = 0; i < int'(line_count); i++) begin
			shadow_valid[i] = 1'b0;
			shadow_dirty[i] = 1'b0;
			shadow_tag[i]   = '0;
		end

		repeat (reset_cycles) @(negedge clock);
		reset = 1'b0;
		for (int k = 0; k < memory_words; k++) begin
			shadow_mem[k] = memory_i.mem[k];
		end

		// Issued during init, so it has to wait for the idle state.
		run_access(1'b0, 1'b1, 1'b0, 32'h0, 32'h0);

		// Index 4: uncached traffic must not disturb the cached line.
		run_access(1'b0, 1'b1, 1'b1, 32'h10, 32'h1234abcd);
		run_access(1'b0, 1'b0, 1'b1, 32'h110, 32'h55aa00ff);
		run_access(1'b0, 1'b0, 1'b0, 32'h110, 32'h0);
		run_access(1'b0, 1'b1, 1'b0, 32'h10, 32'h0);
		// Conflicting store evicts the dirty line.
		run_access(1'b0, 1'b1, 1'b1, 32'h50, 32'hcafe0001);
		run_access(1'b0, 1'b1, 1'b0, 32'h10, 32'h0);

		for (int n = 0; n < op_count; n++) begin
			random_bits(3, choice);
			random_bits(32, data);
			if (choice < 6) begin
				random_bits(6, word);
				run_access(1'b0, 1'b1, choice >= 3, word << 2, data);
			end else begin
				random_bits(4, word);
				run_access(1'b0, 1'b0, choice[0], (word + uncached_base) << 2, data);
			end
		end

		// Drain every dirty line, then memory must match.
		run_access(1'b1, 1'b1, 1'b0, 32'h0, 32'h0);
		for (int k = 0; k < memory_words; k++) begin
			assert (memory_i.mem[k] == shadow_mem[k])
				else report_error($sformatf("memory word %0d is %h, expected %h",
					k, memory_i.mem[k], shadow_mem[k]));
		end
		run_access(1'b1, 1'b1, 1'b0, 32'h0, 32'h0);

		$display("Done: %0d errors, %0d hits, %0d misses, %0d bus writes, %0d cycles",
			errors, expected_hits, expected_misses, bus_writes, cycle);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
logic/dcache_pkg.sv
logic/line_ram_if.sv
logic/line_ram.sv
logic/dcache_ctrl.sv
logic/dcache_stats.sv
logic/dcache_top.sv
sim/bus_memory_model.sv
sim/dcache_tb.sv
